// File: bench/mem_tb_tasks.svh
// ----------------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------------
task automatic check_data(input string what, input logic [data_bits-1:0] got, exp);
    if (got !== exp) begin
        $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_resp(input string what, input mem_pkg::axi_resp_t got, exp);
    if (got !== exp) begin
        $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_id(input string what, input logic [id_bits-1:0] got, exp);
    if (got !== exp) begin
        $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_flag(input string what, input logic got, exp);
    if (got !== exp) begin
        $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        errors++;
    end
endtask

// ----------------------------------------------------------------------------
// Bus tasks that run one transaction each and check the response
// ----------------------------------------------------------------------------
task automatic write_word(input int m, input logic [addr_bits-1:0] addr,
        input logic [data_bits-1:0] data, input logic [strb_bits-1:0] strb);
    logic [id_bits-1:0] id;
    id = next_id;
    next_id++;
    @(negedge clock);
    awvalid[m] = 1'b1;
    awaddr[m] = addr;
    awid[m] = id;
    wvalid[m] = 1'b1;
    wdata[m] = data;
    wstrb[m] = strb;
    #1;
    while (!(awready[m] && wready[m])) begin
        @(negedge clock);
        #1;
    end
    @(negedge clock);
    awvalid[m] = 1'b0;
    wvalid[m] = 1'b0;
    #1;
    check_flag("bvalid one cycle after AW/W", bvalid[m], 1'b1);
    check_resp("bresp", mem_pkg::axi_resp_t'(bresp[m]),
        (addr < mem_limit) ? mem_pkg::OKAY : mem_pkg::SLVERR);
    check_id("bid", bid[m], id);
    // Only strobed bytes of an in-range word change
    for (int b = 0; b < strb_bits; b++) begin
        if (addr < mem_limit && strb[b]) begin
            model[addr / 4][8*b +: 8] = data[8*b +: 8];
        end
    end
endtask

task automatic read_word(input int m, input logic [addr_bits-1:0] addr);
    logic [id_bits-1:0]   id;
    logic [data_bits-1:0] exp_data;
    id = next_id;
    next_id++;
    @(negedge clock);
    arvalid[m] = 1'b1;
    araddr[m] = addr;
    arid[m] = id;
    #1;
    while (!arready[m]) begin
        @(negedge clock);
        #1;
    end
    last_read = m[0];
    exp_data = (addr < mem_limit) ? model[addr / 4] : '0;
    @(negedge clock);
    arvalid[m] = 1'b0;
    #1;
    check_flag("rvalid one cycle after AR", rvalid[m], 1'b1);
    check_flag("rlast with rvalid", rlast[m], 1'b1);
    check_data("rdata", rdata[m], exp_data);
    check_resp("rresp", mem_pkg::axi_resp_t'(rresp[m]),
        (addr < mem_limit) ? mem_pkg::OKAY : mem_pkg::SLVERR);
    check_id("rid", rid[m], id);
endtask

// ----------------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------------
task automatic test_words_and_strobes();
    for (int i = 0; i < 8; i++) begin
        addrs[i] = $random(seed) & (mem_limit - 4);
        write_word(1, addrs[i], $random(seed), '1);
    end
    for (int i = 0; i < 8; i++) begin
        read_word(0, addrs[i]);
    end
    // Partial strobes from alternating masters
    for (int i = 0; i < 8; i++) begin
        write_word(i % 2, addrs[i], $random(seed), strb_bits'(3 * i + 1));
        read_word(1 - i % 2, addrs[i]);
    end
endtask

task automatic test_out_of_range();
    write_word(0, 0, $random(seed), '1);
    // mem_limit lands on word 0 if the range check is missing
    write_word(1, mem_limit, $random(seed), '1);
    write_word(0, 32'hffff_fffc, $random(seed), '1);
    read_word(1, mem_limit);
    read_word(0, 32'h8000_0000);
    read_word(1, 0);
endtask

// Master 0 stalls its read response while master 1 tries to write
task automatic test_backpressure();
    logic [data_bits-1:0] held;
    @(negedge clock);
    rready[0] = 1'b0;
    read_word(0, addrs[2]);
    held = model[addrs[2] / 4];
    fork
        write_word(1, addrs[3], $random(seed), '1);
        begin
            repeat (5) begin
                @(negedge clock);
                #2;
                check_flag("rvalid under back-pressure", rvalid[0], 1'b1);
                check_data("rdata under back-pressure", rdata[0], held);
                check_flag("m1 awready while slave busy", awready[1], 1'b0);
                check_flag("m1 wready while slave busy", wready[1], 1'b0);
            end
            @(negedge clock);
            rready[0] = 1'b1;
        end
    join
    read_word(0, addrs[3]);
endtask

task automatic test_contention();
    logic exp_m1;
    for (int i = 0; i < 4; i++) begin
        // A lone read first sets which master won last
        read_word(i % 2, addrs[i]);
        exp_m1 = !last_read;
        fork
            read_word(0, addrs[i + 4]);
            read_word(1, addrs[7 - i]);
            begin
                @(negedge clock);
                #2;
                check_flag("m1 read grant", arready[1], exp_m1);
                check_flag("m0 read grant", arready[0], !exp_m1);
            end
        join
    end
endtask

// File: bench/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;

    localparam int mem_words = 1024;
    localparam int addr_bits = mem_pkg::addr_width;
    localparam int data_bits = mem_pkg::data_width;
    localparam int strb_bits = mem_pkg::strb_width;
    localparam int id_bits   = mem_pkg::id_width;

    // First byte address past the end of the memory
    localparam logic [addr_bits-1:0] mem_limit = 4 * mem_words;

    logic clock;
    logic reset;

    // Index 0 is master 0, index 1 is master 1
    logic [1:0]                 awvalid, wvalid, wlast, bready, arvalid, rready;
    logic [1:0][addr_bits-1:0]  awaddr, araddr;
    logic [1:0][id_bits-1:0]    awid, arid;
    logic [1:0][data_bits-1:0]  wdata;
    logic [1:0][strb_bits-1:0]  wstrb;
    wire  [1:0]                 awready, wready, bvalid, arready, rvalid, rlast;
    wire  [1:0][1:0]            bresp, rresp;
    wire  [1:0][id_bits-1:0]    bid, rid;
    wire  [1:0][data_bits-1:0]  rdata;

    // ------------------------------------------------------------------------
    // Reference model and test state
    // ------------------------------------------------------------------------
    logic [data_bits-1:0] model [mem_words];
    logic [addr_bits-1:0] addrs [8];
    logic [id_bits-1:0]   next_id;
    logic                 last_read;
    integer               seed;
    int                   errors;

    mem_subsystem #(
        .mem_words (mem_words)
    ) uut (
        .clock (clock),
        .reset (reset),
        .m0_awvalid (awvalid[0]), .m0_awready (awready[0]), .m0_awaddr (awaddr[0]),
        .m0_awid (awid[0]), .m0_wvalid (wvalid[0]), .m0_wready (wready[0]),
        .m0_wdata (wdata[0]), .m0_wstrb (wstrb[0]), .m0_wlast (wlast[0]),
        .m0_bvalid (bvalid[0]), .m0_bready (bready[0]), .m0_bresp (bresp[0]), .m0_bid (bid[0]),
        .m0_arvalid (arvalid[0]), .m0_arready (arready[0]), .m0_araddr (araddr[0]),
        .m0_arid (arid[0]), .m0_rvalid (rvalid[0]), .m0_rready (rready[0]),
        .m0_rdata (rdata[0]), .m0_rresp (rresp[0]), .m0_rid (rid[0]), .m0_rlast (rlast[0]),
        .m1_awvalid (awvalid[1]), .m1_awready (awready[1]), .m1_awaddr (awaddr[1]),
        .m1_awid (awid[1]), .m1_wvalid (wvalid[1]), .m1_wready (wready[1]),
        .m1_wdata (wdata[1]), .m1_wstrb (wstrb[1]), .m1_wlast (wlast[1]),
        .m1_bvalid (bvalid[1]), .m1_bready (bready[1]), .m1_bresp (bresp[1]), .m1_bid (bid[1]),
        .m1_arvalid (arvalid[1]), .m1_arready (arready[1]), .m1_araddr (araddr[1]),
        .m1_arid (arid[1]), .m1_rvalid (rvalid[1]), .m1_rready (rready[1]),
        .m1_rdata (rdata[1]), .m1_rresp (rresp[1]), .m1_rid (rid[1]), .m1_rlast (rlast[1])
    );

    `include "mem_tb_tasks.svh"

    always #4 clock = ~clock;

    // Whole sequence takes a few hundred cycles
    initial begin
        #20000;
        $display("Run timed out after 20000 ns, a handshake never completed");
        $display("Run ended with %0d errors before the timeout", errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        seed = 32'h502b;
        errors = 0;
        next_id = '0;
        last_read = 1'b0;
        awvalid = '0;
        wvalid = '0;
        arvalid = '0;
        wlast = '1;
        bready = '1;
        rready = '1;
        awaddr = '0;
        araddr = '0;
        awid = '0;
        arid = '0;
        wdata = '0;
        wstrb = '0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        #1;
        for (int m = 0; m < 2; m++) begin
            check_flag("rvalid after reset", rvalid[m], 1'b0);
            check_flag("bvalid after reset", bvalid[m], 1'b0);
            check_flag("arready after reset", arready[m], 1'b1);
        end
        test_words_and_strobes();
        test_out_of_range();
        test_backpressure();
        test_contention();
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+bench
logic/mem_pkg.sv
logic/axi_sram.sv
logic/axi_arbiter.sv
logic/mem_subsystem.sv
bench/mem_subsystem_tb.sv

// File: logic/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter (
    input  logic                              clock,
    input  logic                              reset,

    // Master 0, instruction fetch
    input  logic                              m0_awvalid,
    output logic                              m0_awready,
    input  logic [mem_pkg::addr_width-1:0]    m0_awaddr,
    input  logic [mem_pkg::id_width-1:0]      m0_awid,
    input  logic                              m0_wvalid,
    output logic                              m0_wready,
    input  logic [mem_pkg::data_width-1:0]    m0_wdata,
    input  logic [mem_pkg::strb_width-1:0]    m0_wstrb,
    input  logic                              m0_wlast,
    output logic                              m0_bvalid,
    input  logic                              m0_bready,
    output mem_pkg::axi_resp_t                m0_bresp,
    output logic [mem_pkg::id_width-1:0]      m0_bid,
    input  logic                              m0_arvalid,
    output logic                              m0_arready,
    input  logic [mem_pkg::addr_width-1:0]    m0_araddr,
    input  logic [mem_pkg::id_width-1:0]      m0_arid,
    output logic                              m0_rvalid,
    input  logic                              m0_rready,
    output logic [mem_pkg::data_width-1:0]    m0_rdata,
    output mem_pkg::axi_resp_t                m0_rresp,
    output logic [mem_pkg::id_width-1:0]      m0_rid,
    output logic                              m0_rlast,

    // Master 1, load/store
    input  logic                              m1_awvalid,
    output logic                              m1_awready,
    input  logic [mem_pkg::addr_width-1:0]    m1_awaddr,
    input  logic [mem_pkg::id_width-1:0]      m1_awid,
    input  logic                              m1_wvalid,
    output logic                              m1_wready,
    input  logic [mem_pkg::data_width-1:0]    m1_wdata,
    input  logic [mem_pkg::strb_width-1:0]    m1_wstrb,
    input  logic                              m1_wlast,
    output logic                              m1_bvalid,
    input  logic                              m1_bready,
    output mem_pkg::axi_resp_t                m1_bresp,
    output logic [mem_pkg::id_width-1:0]      m1_bid,
    input  logic                              m1_arvalid,
    output logic                              m1_arready,
    input  logic [mem_pkg::addr_width-1:0]    m1_araddr,
    input  logic [mem_pkg::id_width-1:0]      m1_arid,
    output logic                              m1_rvalid,
    input  logic                              m1_rready,
    output logic [mem_pkg::data_width-1:0]    m1_rdata,
    output mem_pkg::axi_resp_t                m1_rresp,
    output logic [mem_pkg::id_width-1:0]      m1_rid,
    output logic                              m1_rlast,

    // Slave side, no ids
    output logic                              s_awvalid,
    input  logic                              s_awready,
    output logic [mem_pkg::addr_width-1:0]    s_awaddr,
    output logic                              s_wvalid,
    input  logic                              s_wready,
    output logic [mem_pkg::data_width-1:0]    s_wdata,
    output logic [mem_pkg::strb_width-1:0]    s_wstrb,
    input  logic                              s_bvalid,
    output logic                              s_bready,
    input  mem_pkg::axi_resp_t                s_bresp,
    output logic                              s_arvalid,
    input  logic                              s_arready,
    output logic [mem_pkg::addr_width-1:0]    s_araddr,
    input  logic                              s_rvalid,
    output logic                              s_rready,
    input  logic [mem_pkg::data_width-1:0]    s_rdata,
    input  mem_pkg::axi_resp_t                s_rresp,
    input  logic                              s_rlast
);

    // Owner index doubles as the last winner for round-robin
    logic                          rd_busy;
    logic                          rd_owner;
    logic [mem_pkg::id_width-1:0]  rd_id;
    logic                          rd_pick;
    logic                          wr_busy;
    logic                          wr_owner;
    logic [mem_pkg::id_width-1:0]  wr_id;
    logic                          wr_pick;
    logic                          wr_req0;
    logic                          wr_req1;

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------

    // Alternate only when both masters ask in the same cycle
    assign rd_pick = (m0_arvalid && m1_arvalid) ? !rd_owner : m1_arvalid;

    assign s_arvalid = !rd_busy && (rd_pick ? m1_arvalid : m0_arvalid);
    assign s_araddr  = rd_pick ? m1_araddr : m0_araddr;

    // Both readies stay up while nobody is asking
    assign m0_arready = s_arready && !rd_busy && !rd_pick;
    assign m1_arready = s_arready && !rd_busy && (rd_pick || !m0_arvalid);

    assign s_rready  = rd_busy && (rd_owner ? m1_rready : m0_rready);
    assign m0_rvalid = rd_busy && !rd_owner && s_rvalid;
    assign m1_rvalid = rd_busy && rd_owner && s_rvalid;
    assign m0_rdata  = s_rdata;
    assign m1_rdata  = s_rdata;
    assign m0_rresp  = s_rresp;
    assign m1_rresp  = s_rresp;
    assign m0_rlast  = s_rlast;
    assign m1_rlast  = s_rlast;
    assign m0_rid    = rd_id;
    assign m1_rid    = rd_id;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_busy  <= 1'b0;
            rd_owner <= 1'b0;
            rd_id    <= '0;
        end else if (!rd_busy && s_arvalid && s_arready) begin
            rd_busy  <= 1'b1;
            rd_owner <= rd_pick;
            rd_id    <= rd_pick ? m1_arid : m0_arid;
        end else if (rd_busy && s_rvalid && s_rready) begin
            rd_busy <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------

    // wlast is always one for single-beat transfers and is not looked at
    assign wr_req0 = m0_awvalid && m0_wvalid;
    assign wr_req1 = m1_awvalid && m1_wvalid;
    assign wr_pick = (wr_req0 && wr_req1) ? !wr_owner : wr_req1;

    assign s_awvalid = !wr_busy && (wr_pick ? m1_awvalid : m0_awvalid);
    assign s_wvalid  = !wr_busy && (wr_pick ? m1_wvalid : m0_wvalid);
    assign s_awaddr  = wr_pick ? m1_awaddr : m0_awaddr;
    assign s_wdata   = wr_pick ? m1_wdata : m0_wdata;
    assign s_wstrb   = wr_pick ? m1_wstrb : m0_wstrb;

    // Only the picked master ever sees the write readies
    assign m0_awready = s_awready && !wr_busy && !wr_pick;
    assign m1_awready = s_awready && !wr_busy && wr_pick;
    assign m0_wready  = s_wready && !wr_busy && !wr_pick;
    assign m1_wready  = s_wready && !wr_busy && wr_pick;

    assign s_bready  = wr_busy && (wr_owner ? m1_bready : m0_bready);
    assign m0_bvalid = wr_busy && !wr_owner && s_bvalid;
    assign m1_bvalid = wr_busy && wr_owner && s_bvalid;
    assign m0_bresp  = s_bresp;
    assign m1_bresp  = s_bresp;
    assign m0_bid    = wr_id;
    assign m1_bid    = wr_id;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_busy  <= 1'b0;
            wr_owner <= 1'b0;
            wr_id    <= '0;
        end else if (!wr_busy && s_awvalid && s_awready && s_wvalid && s_wready) begin
            wr_busy  <= 1'b1;
            wr_owner <= wr_pick;
            wr_id    <= wr_pick ? m1_awid : m0_awid;
        end else if (wr_busy && s_bvalid && s_bready) begin
            wr_busy <= 1'b0;
        end
    end

endmodule

// File: logic/axi_sram.sv
`timescale 1ns/1ps

module axi_sram #(
    parameter int mem_words = 1024
) (
    input  logic                              clock,
    input  logic                              reset,

    // Write address channel
    input  logic                              s_awvalid,
    output logic                              s_awready,
    input  logic [mem_pkg::addr_width-1:0]    s_awaddr,

    // Write data channel
    input  logic                              s_wvalid,
    output logic                              s_wready,
    input  logic [mem_pkg::data_width-1:0]    s_wdata,
    input  logic [mem_pkg::strb_width-1:0]    s_wstrb,

    // Write response channel
    output logic                              s_bvalid,
    input  logic                              s_bready,
    output mem_pkg::axi_resp_t                s_bresp,

    // Read address channel
    input  logic                              s_arvalid,
    output logic                              s_arready,
    input  logic [mem_pkg::addr_width-1:0]    s_araddr,

    // Read data channel
    output logic                              s_rvalid,
    input  logic                              s_rready,
    output logic [mem_pkg::data_width-1:0]    s_rdata,
    output mem_pkg::axi_resp_t                s_rresp,
    output logic                              s_rlast
);

    localparam int index_width = $clog2(mem_words);

    // First byte address past the end of the array
    localparam logic [mem_pkg::addr_width-1:0] mem_limit =
        mem_pkg::addr_width'(4 * mem_words);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_write
    } state_t;

    state_t                          state;
    logic                            ready_en;
    logic [mem_pkg::data_width-1:0]  mem [mem_words];
    logic [index_width-1:0]          rd_index;
    logic [index_width-1:0]          wr_index;
    logic                            rd_in_range;
    logic                            wr_in_range;
    logic                            rd_fire;
    logic                            wr_fire;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------
    assign rd_index    = s_araddr[index_width+1:2];
    assign wr_index    = s_awaddr[index_width+1:2];
    assign rd_in_range = s_araddr < mem_limit;
    assign wr_in_range = s_awaddr < mem_limit;

    // ------------------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------------------

    // Held low until the first edge after reset
    assign s_arready = ready_en && (state == st_idle);

    // A pending read wins, and AW and W are only taken together
    assign s_awready = ready_en && (state == st_idle) && !s_arvalid && s_wvalid;
    assign s_wready  = ready_en && (state == st_idle) && !s_arvalid && s_awvalid;

    assign rd_fire = s_arvalid && s_arready;
    assign wr_fire = s_awvalid && s_awready && s_wvalid && s_wready;

    // Responses come straight from the state
    assign s_rvalid = (state == st_read);
    assign s_rlast  = s_rvalid;
    assign s_bvalid = (state == st_write);

    // ------------------------------------------------------------------------
    // One transaction at a time
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= st_idle;
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            case (state)
                st_idle: begin
                    if (rd_fire) begin
                        state <= st_read;
                    end else if (wr_fire) begin
                        state <= st_write;
                    end
                end
                // Stay until the master takes the response
                st_read: begin
                    if (s_rready) begin
                        state <= st_idle;
                    end
                end
                st_write: begin
                    if (s_bready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Response payload, captured on the request handshake
    always_ff @(posedge clock) begin
        if (rd_fire) begin
            if (rd_in_range) begin
                s_rdata <= mem[rd_index];
                s_rresp <= mem_pkg::OKAY;
            end else begin
                s_rdata <= '0;
                s_rresp <= mem_pkg::SLVERR;
            end
        end
        if (wr_fire) begin
            if (wr_in_range) begin
                s_bresp <= mem_pkg::OKAY;
            end else begin
                s_bresp <= mem_pkg::SLVERR;
            end
        end
    end

    // Byte lanes written only where the strobe is set
    always_ff @(posedge clock) begin
        if (wr_fire && wr_in_range) begin
            for (int b = 0; b < mem_pkg::strb_width; b++) begin
                if (s_wstrb[b]) begin
                    mem[wr_index][8*b +: 8] <= s_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: logic/mem_pkg.sv
package mem_pkg;

    // ------------------------------------------------------------------------
    // Bus widths shared by every port of the memory subsystem
    // ------------------------------------------------------------------------
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;
    localparam int id_width   = 4;

    // ------------------------------------------------------------------------
    // Response codes
    // ------------------------------------------------------------------------

    // Only the two codes the slave can produce
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

// File: logic/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int mem_words = 1024
) (
    input  logic                              clock,
    input  logic                              reset,

    // Master 0, instruction fetch
    input  logic                              m0_awvalid,
    output logic                              m0_awready,
    input  logic [mem_pkg::addr_width-1:0]    m0_awaddr,
    input  logic [mem_pkg::id_width-1:0]      m0_awid,
    input  logic                              m0_wvalid,
    output logic                              m0_wready,
    input  logic [mem_pkg::data_width-1:0]    m0_wdata,
    input  logic [mem_pkg::strb_width-1:0]    m0_wstrb,
    input  logic                              m0_wlast,
    output logic                              m0_bvalid,
    input  logic                              m0_bready,
    output mem_pkg::axi_resp_t                m0_bresp,
    output logic [mem_pkg::id_width-1:0]      m0_bid,
    input  logic                              m0_arvalid,
    output logic                              m0_arready,
    input  logic [mem_pkg::addr_width-1:0]    m0_araddr,
    input  logic [mem_pkg::id_width-1:0]      m0_arid,
    output logic                              m0_rvalid,
    input  logic                              m0_rready,
    output logic [mem_pkg::data_width-1:0]    m0_rdata,
    output mem_pkg::axi_resp_t                m0_rresp,
    output logic [mem_pkg::id_width-1:0]      m0_rid,
    output logic                              m0_rlast,

    // Master 1, load/store
    input  logic                              m1_awvalid,
    output logic                              m1_awready,
    input  logic [mem_pkg::addr_width-1:0]    m1_awaddr,
    input  logic [mem_pkg::id_width-1:0]      m1_awid,
    input  logic                              m1_wvalid,
    output logic                              m1_wready,
    input  logic [mem_pkg::data_width-1:0]    m1_wdata,
    input  logic [mem_pkg::strb_width-1:0]    m1_wstrb,
    input  logic                              m1_wlast,
    output logic                              m1_bvalid,
    input  logic                              m1_bready,
    output mem_pkg::axi_resp_t                m1_bresp,
    output logic [mem_pkg::id_width-1:0]      m1_bid,
    input  logic                              m1_arvalid,
    output logic                              m1_arready,
    input  logic [mem_pkg::addr_width-1:0]    m1_araddr,
    input  logic [mem_pkg::id_width-1:0]      m1_arid,
    output logic                              m1_rvalid,
    input  logic                              m1_rready,
    output logic [mem_pkg::data_width-1:0]    m1_rdata,
    output mem_pkg::axi_resp_t                m1_rresp,
    output logic [mem_pkg::id_width-1:0]      m1_rid,
    output logic                              m1_rlast
);

    // ------------------------------------------------------------------------
    // Arbiter to slave link
    // ------------------------------------------------------------------------
    logic                            s_awvalid;
    logic                            s_awready;
    logic [mem_pkg::addr_width-1:0]  s_awaddr;
    logic                            s_wvalid;
    logic                            s_wready;
    logic [mem_pkg::data_width-1:0]  s_wdata;
    logic [mem_pkg::strb_width-1:0]  s_wstrb;
    logic                            s_bvalid;
    logic                            s_bready;
    mem_pkg::axi_resp_t              s_bresp;
    logic                            s_arvalid;
    logic                            s_arready;
    logic [mem_pkg::addr_width-1:0]  s_araddr;
    logic                            s_rvalid;
    logic                            s_rready;
    logic [mem_pkg::data_width-1:0]  s_rdata;
    mem_pkg::axi_resp_t              s_rresp;
    logic                            s_rlast;

    // Port names match one to one on both instances
    axi_arbiter u_arbiter (.*);

    axi_sram #(
        .mem_words (mem_words)
    ) u_sram (.*);

endmodule
